// File: hdl/dcache_pkg.sv
/* data cache shared definitions
   geometry, AHB codes, controller states and the structs between blocks */
package dcache_pkg;

  ////////////////////////////////////////
  // geometry, 16 lines of 4 words
  ////////////////////////////////////////
  localparam int XLEN       = 32;
  localparam int LINE_WORDS = 4;    // words per line
  localparam int SETS       = 16;   // direct mapped
  localparam int IDX_BITS   = 4;    // set index
  localparam int OFS_BITS   = 4;    // byte offset in line
  localparam int TAG_BITS   = XLEN - IDX_BITS - OFS_BITS;   // 24

  ////////////////////////////////////////
  // AHB3-Lite codes
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR4  = 3'b011
  } hburst_t;

  // also the cpu access size
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

  // controller states, flush first so reset lands there
  typedef enum logic [2:0] {
    ST_FLUSH,
    ST_IDLE,
    ST_LOOKUP,
    ST_FILL,
    ST_WRITE,
    ST_ACK
  } dc_state_t;

  ////////////////////////////////////////
  // block interfaces
  ////////////////////////////////////////
  typedef struct packed {
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] d;      // store data on its byte lanes
    logic            we;
    hsize_t          size;
  } cpu_req_t;               // 68 bits

  typedef struct packed {
    logic            stb;    // one cycle start pulse
    logic [XLEN-1:0] adr;
    hburst_t         burst;
    hsize_t          size;
    logic            we;
    logic [XLEN-1:0] wdata;
  } biu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            rack;   // one per read beat
    logic            wack;   // one per write
    logic            err;    // replaces the ack
  } biu_rsp_t;

endpackage

// File: hdl/dcache_req_check.sv
/* request alignment check
   pulses mem_misaligned with an ack and merges the core ack */
`timescale 1ns/1ps

module dcache_req_check
  import dcache_pkg::*;
(
  input  logic            HCLK,
  input  logic            rst_n,
  input  logic            mem_req,
  input  logic [XLEN-1:0] mem_adr,
  input  hsize_t          mem_size,
  input  logic            core_ack,
  output logic            req_ok,
  output logic            mem_misaligned,
  output logic            mem_ack
);

  logic misal;   // address not on a size boundary

  always_comb
    case (mem_size)
      BYTE:    misal = 1'b0;
      HALF:    misal = mem_adr[0];
      default: misal = |mem_adr[1:0];   // word
    endcase

  assign req_ok = mem_req & ~misal;   // core never sees a bad access

  // single pulse, blocked in the cycle after so a held request does not repeat
  always_ff @(posedge HCLK or negedge rst_n)
    if (!rst_n)
      mem_misaligned <= 1'b0;
    else
      mem_misaligned <= mem_req & misal & ~mem_misaligned;

  assign mem_ack = mem_misaligned | core_ack;

endmodule

// File: hdl/dcache_beat_cnt.sv
/* shared counter, fill beat or flush set index */
`timescale 1ns/1ps

module dcache_beat_cnt
  import dcache_pkg::*;
(
  input  logic                HCLK,
  input  logic                rst_n,
  input  logic                clr,
  input  logic                inc,
  input  logic                mode_flush,   // 1 = walk sets, 0 = count beats
  output logic [IDX_BITS-1:0] cnt,
  output logic                last
);

  always_ff @(posedge HCLK or negedge rst_n)
    if (!rst_n)
      cnt <= '0;
    else if (clr)
      cnt <= '0;                  // clear wins over inc
    else if (inc)
      cnt <= cnt + 1'b1;

  // final count depends on what is being walked
  assign last = mode_flush ? (cnt == IDX_BITS'(SETS - 1))
                           : (cnt == IDX_BITS'(LINE_WORDS - 1));

endmodule

// File: hdl/dcache_array.sv
/* tag, valid and data storage
   registered read with tag compare, fill word or byte lane write */
`timescale 1ns/1ps

module dcache_array
  import dcache_pkg::*;
(
  input  logic                HCLK,
  input  logic                rst_n,
  input  logic [XLEN-1:0]     rd_adr,
  input  logic                tag_we,      // write tag of wr_adr
  input  logic                set_valid,   // valid value written with the tag
  input  logic [IDX_BITS-1:0] inv_idx,
  input  logic                inv,
  input  logic                word_we,
  input  logic [1:0]          word_sel,
  input  hsize_t              wr_size,
  input  logic [XLEN-1:0]     wr_adr,
  input  logic [XLEN-1:0]     wdata,
  output logic                hit,
  output logic [XLEN-1:0]     rdata
);

  logic [TAG_BITS-1:0] tag_mem  [SETS];
  logic [XLEN-1:0]     data_mem [SETS*LINE_WORDS];   // {set, word}
  logic [SETS-1:0]     valid;

  logic [IDX_BITS-1:0] rd_idx;
  logic [IDX_BITS-1:0] wr_idx;
  logic [TAG_BITS-1:0] rd_tag;
  logic [XLEN/8-1:0]   be;        // byte lanes to write

  assign rd_idx = rd_adr[OFS_BITS +: IDX_BITS];
  assign wr_idx = wr_adr[OFS_BITS +: IDX_BITS];
  assign rd_tag = rd_adr[XLEN-1 -: TAG_BITS];

  always_comb
    case (wr_size)
      BYTE:    be = 4'b0001 << wr_adr[1:0];
      HALF:    be = wr_adr[1] ? 4'b1100 : 4'b0011;
      default: be = 4'b1111;      // word, also every fill beat
    endcase

  ////////////////////////////////////////
  // valid bits and hit
  ////////////////////////////////////////
  always_ff @(posedge HCLK or negedge rst_n)
    if (!rst_n)
    begin
      valid <= '0;
      hit   <= 1'b0;
    end
    else
    begin
      if (inv)
        valid[inv_idx] <= 1'b0;        // flush walk
      else if (tag_we)
        valid[wr_idx] <= set_valid;
      hit <= valid[rd_idx] & (tag_mem[rd_idx] == rd_tag);
    end

  ////////////////////////////////////////
  // tag and data
  ////////////////////////////////////////
  always_ff @(posedge HCLK)
  begin
    if (tag_we)
      tag_mem[wr_idx] <= wr_adr[XLEN-1 -: TAG_BITS];
    if (word_we)
      for (int b = 0; b < XLEN/8; b++)
        if (be[b])
          data_mem[{wr_idx, word_sel}][8*b +: 8] <= wdata[8*b +: 8];
    rdata <= data_mem[{rd_idx, rd_adr[OFS_BITS-1:2]}];   // word of the line
  end

endmodule

// File: hdl/dcache_fsm.sv
/* data cache controller
   sequences flush, lookup, line fill and write-through around the array */
`timescale 1ns/1ps

module dcache_fsm
  import dcache_pkg::*;
(
  input  logic            HCLK,
  input  logic            rst_n,
  input  cpu_req_t        req,
  input  logic            req_ok,
  input  logic            bu_cacheflush,
  output logic            dcflush_rdy,
  output logic            core_ack,
  output logic [XLEN-1:0] mem_q,
  output logic            mem_err,
  output biu_req_t        biu_req,
  input  biu_rsp_t        biu_rsp
);

  dc_state_t           state;
  dc_state_t           state_nxt;
  cpu_req_t            req_q;       // request held from acceptance
  logic                err_q;       // bus error on this request
  logic [XLEN-1:0]     q_q;         // word for the cpu

  logic [XLEN-1:0]     rd_adr;
  logic                tag_we;
  logic                set_valid;
  logic                inv;
  logic                word_we;
  logic [1:0]          word_sel;
  hsize_t              wr_size;
  logic [XLEN-1:0]     wdata;
  logic                hit;
  logic [XLEN-1:0]     rdata;

  logic                cnt_clr;
  logic                cnt_inc;
  logic                cnt_last;
  logic [IDX_BITS-1:0] cnt;
  logic                fill_word;   // this beat is the requested word

  dcache_array u_array (
    .HCLK      ( HCLK      ),
    .rst_n     ( rst_n     ),
    .rd_adr    ( rd_adr    ),
    .tag_we    ( tag_we    ),
    .set_valid ( set_valid ),
    .inv_idx   ( cnt       ),
    .inv       ( inv       ),
    .word_we   ( word_we   ),
    .word_sel  ( word_sel  ),
    .wr_size   ( wr_size   ),
    .wr_adr    ( req_q.adr ),
    .wdata     ( wdata     ),
    .hit       ( hit       ),
    .rdata     ( rdata     )
  );

  dcache_beat_cnt u_cnt (
    .HCLK       ( HCLK                ),
    .rst_n      ( rst_n               ),
    .clr        ( cnt_clr             ),
    .inc        ( cnt_inc             ),
    .mode_flush ( state == ST_FLUSH   ),
    .cnt        ( cnt                 ),
    .last       ( cnt_last            )
  );

  // read the incoming address while idle so lookup has tag and data
  assign rd_adr    = (state == ST_IDLE) ? req.adr : req_q.adr;
  assign fill_word = (cnt[1:0] == req_q.adr[OFS_BITS-1:2]);

  assign dcflush_rdy = (state != ST_FLUSH);
  assign mem_err     = (state == ST_ACK) & err_q;
  assign mem_q       = q_q;

  ////////////////////////////////////////
  // next state and strobes
  ////////////////////////////////////////
  always_comb
  begin
    state_nxt = state;
    cnt_clr   = 1'b0;
    cnt_inc   = 1'b0;
    inv       = 1'b0;
    tag_we    = 1'b0;
    set_valid = 1'b0;
    word_we   = 1'b0;
    word_sel  = req_q.adr[OFS_BITS-1:2];
    wr_size   = req_q.size;
    wdata     = req_q.d;
    core_ack  = 1'b0;

    // line base burst for reads, byte address single for writes
    biu_req.stb   = 1'b0;
    biu_req.adr   = req_q.we ? req_q.adr : {req_q.adr[XLEN-1:OFS_BITS], {OFS_BITS{1'b0}}};
    biu_req.burst = req_q.we ? SINGLE : INCR4;
    biu_req.size  = req_q.we ? req_q.size : WORD;
    biu_req.we    = req_q.we;
    biu_req.wdata = req_q.d;

    case (state)
      ST_FLUSH:
      begin
        inv     = 1'b1;                 // one set per cycle
        cnt_inc = 1'b1;
        if (cnt_last)
          state_nxt = ST_IDLE;
      end
      ST_IDLE:
      begin
        if (bu_cacheflush)
        begin
          cnt_clr   = 1'b1;
          state_nxt = ST_FLUSH;
        end
        else if (req_ok)
          state_nxt = ST_LOOKUP;
      end
      ST_LOOKUP:
      begin
        if (req_q.we)
        begin
          biu_req.stb = 1'b1;           // write-through, hit or not
          state_nxt   = ST_WRITE;
        end
        else if (!hit)
        begin
          biu_req.stb = 1'b1;
          cnt_clr     = 1'b1;
          tag_we      = 1'b1;           // new tag, line invalid until last beat
          state_nxt   = ST_FILL;
        end
        else
          state_nxt = ST_ACK;
      end
      ST_FILL:
      begin
        word_sel = cnt[1:0];
        wr_size  = WORD;
        wdata    = biu_rsp.rdata;
        if (biu_rsp.err)
          state_nxt = ST_ACK;           // line stays invalid
        else if (biu_rsp.rack)
        begin
          word_we = 1'b1;
          cnt_inc = 1'b1;
          if (cnt_last)
          begin
            tag_we    = 1'b1;
            set_valid = 1'b1;
            state_nxt = ST_ACK;
          end
        end
      end
      ST_WRITE:
      begin
        if (biu_rsp.err)
          state_nxt = ST_ACK;
        else if (biu_rsp.wack)
        begin
          word_we   = hit;              // no allocate on a miss
          state_nxt = ST_ACK;
        end
      end
      ST_ACK:
      begin
        core_ack  = 1'b1;
        state_nxt = ST_IDLE;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge HCLK or negedge rst_n)
    if (!rst_n)
    begin
      state <= ST_FLUSH;                // invalidate all sets out of reset
      err_q <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (state == ST_LOOKUP)
        err_q <= 1'b0;
      else if (biu_rsp.err)
        err_q <= 1'b1;
    end

  // request and returned word
  always_ff @(posedge HCLK)
  begin
    if (state == ST_IDLE && req_ok)
      req_q <= req;
    if (state == ST_LOOKUP)
      q_q <= rdata;                     // hit data
    else if (state == ST_FILL && biu_rsp.rack && fill_word)
      q_q <= biu_rsp.rdata;
  end

endmodule

// File: hdl/dcache_ahb_biu.sv
/* AHB3-Lite master for the data cache
   overlapped address and data phases, INCR4 fills and single writes */
`timescale 1ns/1ps

module dcache_ahb_biu
  import dcache_pkg::*;
(
  input  logic            HCLK,
  input  logic            rst_n,
  input  biu_req_t        biu_req,
  output biu_rsp_t        biu_rsp,
  output logic            HSEL,
  output logic [XLEN-1:0] HADDR,
  output logic [XLEN-1:0] HWDATA,
  output logic            HWRITE,
  output hsize_t          HSIZE,
  output hburst_t         HBURST,
  output logic [3:0]      HPROT,
  output htrans_t         HTRANS,
  input  logic [XLEN-1:0] HRDATA,
  input  logic            HREADY,
  input  logic            HRESP
);

  logic       a_act;    // address phase on the bus
  logic [1:0] a_left;   // beats still to address after this one
  logic       d_act;    // data phase on the bus
  logic       d_we;     // data phase is a write
  logic       d_done;   // data phase ends this cycle

  assign HSEL   = a_act;
  assign HPROT  = 4'b0011;   // data, privileged, not bufferable or cacheable
  assign d_done = d_act & HREADY;

  assign biu_rsp.rdata = HRDATA;
  assign biu_rsp.rack  = d_done & ~HRESP & ~d_we;
  assign biu_rsp.wack  = d_done & ~HRESP &  d_we;
  assign biu_rsp.err   = d_done &  HRESP;

  ////////////////////////////////////////
  // phase pipeline
  ////////////////////////////////////////
  always_ff @(posedge HCLK or negedge rst_n)
    if (!rst_n)
    begin
      a_act  <= 1'b0;
      a_left <= 2'd0;
      d_act  <= 1'b0;
      d_we   <= 1'b0;
      HTRANS <= IDLE;
      HWRITE <= 1'b0;
      HSIZE  <= WORD;
      HBURST <= SINGLE;
    end
    else if (biu_req.stb)            // only strobed while bus unit is idle
    begin
      a_act  <= 1'b1;
      a_left <= (biu_req.burst == INCR4) ? 2'd3 : 2'd0;
      HTRANS <= NONSEQ;
      HWRITE <= biu_req.we;
      HSIZE  <= biu_req.size;
      HBURST <= biu_req.burst;
    end
    else if (d_act && HRESP)
    begin
      // error, go idle in the first response cycle and drop the rest
      a_act  <= 1'b0;
      HTRANS <= IDLE;
      if (HREADY)
        d_act <= 1'b0;
    end
    else if (HREADY)
    begin
      d_act <= a_act;                // address phase moves to data phase
      d_we  <= HWRITE;
      if (a_act && a_left != 2'd0)
      begin
        a_left <= a_left - 2'd1;
        HTRANS <= SEQ;
      end
      else
      begin
        a_act  <= 1'b0;
        HTRANS <= IDLE;
      end
    end

  // address and write data
  always_ff @(posedge HCLK)
    if (biu_req.stb)
    begin
      HADDR  <= biu_req.adr;
      HWDATA <= biu_req.wdata;       // held until the write data phase ends
    end
    else if (HREADY && a_act && a_left != 2'd0)
      HADDR <= HADDR + 32'd4;        // word step, bursts are word sized

endmodule

// File: hdl/dcache_ahb3lite.sv
/* data cache subsystem
   alignment check, cache core and AHB3-Lite bus unit */
`timescale 1ns/1ps

module dcache_ahb3lite
  import dcache_pkg::*;
(
  input  logic            HCLK,
  input  logic            rst_n,

  // AHB3-Lite master
  output logic            HSEL,
  output logic [XLEN-1:0] HADDR,
  input  logic [XLEN-1:0] HRDATA,
  output logic [XLEN-1:0] HWDATA,
  output logic            HWRITE,
  output hsize_t          HSIZE,
  output hburst_t         HBURST,
  output logic [3:0]      HPROT,
  output htrans_t         HTRANS,
  input  logic            HREADY,
  input  logic            HRESP,

  // cpu load/store port
  input  logic [XLEN-1:0] mem_adr,
  input  logic [XLEN-1:0] mem_d,            // on its byte lanes
  input  logic            mem_req,          // held until mem_ack
  input  logic            mem_we,
  input  hsize_t          mem_size,
  output logic [XLEN-1:0] mem_q,            // full word, cpu picks bytes
  output logic            mem_ack,
  output logic            mem_err,
  output logic            mem_misaligned,
  input  logic            bu_cacheflush,
  output logic            dcflush_rdy
);

  cpu_req_t cpu_req;
  logic     req_ok;      // aligned request
  logic     core_ack;
  biu_req_t biu_req;
  biu_rsp_t biu_rsp;

  assign cpu_req = '{adr: mem_adr, d: mem_d, we: mem_we, size: mem_size};

  dcache_req_check u_req_check (
    .HCLK           ( HCLK           ),
    .rst_n          ( rst_n          ),
    .mem_req        ( mem_req        ),
    .mem_adr        ( mem_adr        ),
    .mem_size       ( mem_size       ),
    .core_ack       ( core_ack       ),
    .req_ok         ( req_ok         ),
    .mem_misaligned ( mem_misaligned ),
    .mem_ack        ( mem_ack        )
  );

  dcache_fsm u_fsm (
    .HCLK          ( HCLK          ),
    .rst_n         ( rst_n         ),
    .req           ( cpu_req       ),
    .req_ok        ( req_ok        ),
    .bu_cacheflush ( bu_cacheflush ),
    .dcflush_rdy   ( dcflush_rdy   ),
    .core_ack      ( core_ack      ),
    .mem_q         ( mem_q         ),
    .mem_err       ( mem_err       ),
    .biu_req       ( biu_req       ),
    .biu_rsp       ( biu_rsp       )
  );

  dcache_ahb_biu u_biu (
    .HCLK    ( HCLK    ),
    .rst_n   ( rst_n   ),
    .biu_req ( biu_req ),
    .biu_rsp ( biu_rsp ),
    .HSEL    ( HSEL    ),
    .HADDR   ( HADDR   ),
    .HWDATA  ( HWDATA  ),
    .HWRITE  ( HWRITE  ),
    .HSIZE   ( HSIZE   ),
    .HBURST  ( HBURST  ),
    .HPROT   ( HPROT   ),
    .HTRANS  ( HTRANS  ),
    .HRDATA  ( HRDATA  ),
    .HREADY  ( HREADY  ),
    .HRESP   ( HRESP   )
  );

endmodule

// File: tests/tb_dcache.sv
/* data cache testbench
   AHB slave memory with wait states and an error range
   and a table of cpu operations applied in a loop */
`timescale 1ns/1ps

module tb_dcache
  import dcache_pkg::*;
();

  typedef enum logic [1:0] {OP_RD, OP_WR, OP_FL, OP_FW} op_t;

  typedef struct packed {
    op_t         op;
    logic [31:0] adr;
    hsize_t      size;
    logic [31:0] d;        // store data on its byte lanes
    logic [31:0] q;        // expected read word
    logic [3:0]  starts;   // expected NONSEQ starts
    logic        err;      // expected mem_err
    logic        mis;      // expected mem_misaligned
  } op_entry_t;

  logic            HCLK;
  logic            rst_n;
  logic            HSEL;
  logic [XLEN-1:0] HADDR;
  logic [XLEN-1:0] HRDATA;
  logic [XLEN-1:0] HWDATA;
  logic            HWRITE;
  hsize_t          HSIZE;
  hburst_t         HBURST;
  logic [3:0]      HPROT;
  htrans_t         HTRANS;
  logic            HREADY;
  logic            HRESP;
  logic [XLEN-1:0] mem_adr;
  logic [XLEN-1:0] mem_d;
  logic            mem_req;
  logic            mem_we;
  hsize_t          mem_size;
  logic [XLEN-1:0] mem_q;
  logic            mem_ack;
  logic            mem_err;
  logic            mem_misaligned;
  logic            bu_cacheflush;
  logic            dcflush_rdy;

  op_entry_t   ops[$];
  string       names[$];
  int          errors;
  int          failed;
  int          cycles;
  int          limit;                 // watchdog limit of 200 cycles per entry
  integer      seed;

  logic [31:0] mem [logic [31:0]];    // written words only
  int          starts;                // NONSEQ address phases seen
  logic [31:0] last_wr_adr;
  hsize_t      last_wr_size;
  logic [31:0] last_wr_data;

  dcache_ahb3lite u_dut (.*);

  // unwritten words read back as address xor 5a5a0000
  function automatic logic [31:0] read_word(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    if (mem.exists(w))
      return mem[w];
    return w ^ 32'h5a5a0000;
  endfunction

  function automatic logic lane_on(input hsize_t size, input logic [1:0] a, input int b);
    case (size)
      BYTE:    return b == int'(a);
      HALF:    return (b / 2) == int'(a[1]);
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic in_err_range(input logic [31:0] a);
    return a[31:8] == 24'h0000f0;     // f000..f0ff answers with ERROR
  endfunction

  ////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////
  initial
  begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;
  end

  initial
  begin
    cycles = 0;
    do
    begin
      @(posedge HCLK);
      cycles++;
    end
    while (limit == 0 || cycles <= limit);
    $display("timeout after %0d cycles, the DUT stopped responding", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // AHB slave memory
  ////////////////////////////////////////
  initial
  begin : ahb_slave
    logic        d_valid;
    logic        d_err;
    logic        err_first;        // first cycle of the two cycle ERROR
    logic        d_write;
    logic [31:0] d_adr;
    hsize_t      d_size;
    htrans_t     s_trans;
    logic [31:0] s_addr;
    logic        s_write;
    hsize_t      s_size;
    logic [31:0] s_wdata;
    logic [31:0] w;
    seed      = 8216;
    starts    = 0;
    d_valid   = 1'b0;
    d_err     = 1'b0;
    err_first = 1'b0;
    d_write   = 1'b0;
    d_adr     = '0;
    d_size    = WORD;
    HREADY    = 1'b1;
    HRESP     = 1'b0;
    HRDATA    = '0;
    forever
    begin
      @(negedge HCLK);             // master outputs settled
      s_trans = HTRANS;
      s_addr  = HADDR;
      s_write = HWRITE;
      s_size  = HSIZE;
      s_wdata = HWDATA;
      // master control of each address phase
      if (s_trans == NONSEQ || s_trans == SEQ)
      begin
        if (HSEL !== 1'b1)
          show_error("ahb_slave", "HSEL low during an address phase");
        if (HPROT[0] !== 1'b1)
          show_error("ahb_slave", "HPROT does not mark a data access");
      end
      if (s_trans == NONSEQ && s_write && HBURST !== SINGLE)
        show_error("ahb_slave", "store is not a SINGLE transfer");
      if (s_trans == NONSEQ && !s_write
          && (HBURST !== INCR4 || s_size !== WORD || s_addr[3:0] !== 4'h0))
        show_error("ahb_slave", "line fill is not a word INCR4 burst from the line base");
      @(posedge HCLK);
      if (d_valid && HREADY)
      begin
        if (d_write && !d_err)
        begin
          w = read_word(d_adr);
          for (int b = 0; b < 4; b++)
            if (lane_on(d_size, d_adr[1:0], b))
              w[8*b +: 8] = s_wdata[8*b +: 8];
          mem[{d_adr[31:2], 2'b00}] = w;
          last_wr_adr  = d_adr;
          last_wr_size = d_size;
          last_wr_data = s_wdata;
        end
        d_valid = 1'b0;
      end
      if (HREADY && (s_trans == NONSEQ || s_trans == SEQ))
      begin
        d_valid   = 1'b1;            // address phase taken
        d_adr     = s_addr;
        d_write   = s_write;
        d_size    = s_size;
        d_err     = in_err_range(s_addr);
        err_first = 1'b1;
        if (s_trans == NONSEQ)
          starts++;
      end
      #1;
      if (d_valid && d_err)
      begin
        HRESP     = 1'b1;
        HREADY    = ~err_first;
        err_first = 1'b0;
      end
      else
      begin
        HRESP  = 1'b0;
        HREADY = d_valid ? (($random(seed) & 3) != 0) : 1'b1;   // random waits
      end
      HRDATA = read_word(d_adr);
    end
  end

  ////////////////////////////////////////
  // operation table
  ////////////////////////////////////////
  function automatic void add_op(input string name, input op_t op, input logic [31:0] adr,
                                 input hsize_t size, input logic [31:0] d, input logic [31:0] q,
                                 input logic [3:0] n_starts, input logic err, input logic mis);
    ops.push_back('{op, adr, size, d, q, n_starts, err, mis});
    names.push_back(name);
  endfunction

  function automatic void load_table();
    add_op("reset_flush",    OP_FW, 32'h0,    WORD, 32'h0,        32'h0,        4'd0, 1'b0, 1'b0);
    add_op("rd_miss",        OP_RD, 32'h1004, WORD, 32'h0,        32'h5a5a1004, 4'd1, 1'b0, 1'b0);
    add_op("rd_hit",         OP_RD, 32'h1008, WORD, 32'h0,        32'h5a5a1008, 4'd0, 1'b0, 1'b0);
    add_op("wr_hit_byte",    OP_WR, 32'h1009, BYTE, 32'h0000a500, 32'h0,        4'd1, 1'b0, 1'b0);
    add_op("rd_merged_byte", OP_RD, 32'h1008, WORD, 32'h0,        32'h5a5aa508, 4'd0, 1'b0, 1'b0);
    add_op("wr_hit_half",    OP_WR, 32'h100e, HALF, 32'hbeef0000, 32'h0,        4'd1, 1'b0, 1'b0);
    add_op("rd_merged_half", OP_RD, 32'h100c, WORD, 32'h0,        32'hbeef100c, 4'd0, 1'b0, 1'b0);
    add_op("wr_miss",        OP_WR, 32'h2040, WORD, 32'h12345678, 32'h0,        4'd1, 1'b0, 1'b0);
    add_op("rd_no_allocate", OP_RD, 32'h2040, WORD, 32'h0,        32'h12345678, 4'd1, 1'b0, 1'b0);
    add_op("rd_hit_again",   OP_RD, 32'h1004, WORD, 32'h0,        32'h5a5a1004, 4'd0, 1'b0, 1'b0);
    add_op("mis_half",       OP_RD, 32'h1001, HALF, 32'h0,        32'h0,        4'd0, 1'b0, 1'b1);
    add_op("mis_word",       OP_WR, 32'h1002, WORD, 32'hdeadbeef, 32'h0,        4'd0, 1'b0, 1'b1);
    add_op("flush",          OP_FL, 32'h0,    WORD, 32'h0,        32'h0,        4'd0, 1'b0, 1'b0);
    add_op("rd_after_flush", OP_RD, 32'h100c, WORD, 32'h0,        32'hbeef100c, 4'd1, 1'b0, 1'b0);
    add_op("rd_err",         OP_RD, 32'hf008, WORD, 32'h0,        32'h0,        4'd1, 1'b1, 1'b0);
    add_op("rd_err_again",   OP_RD, 32'hf008, WORD, 32'h0,        32'h0,        4'd1, 1'b1, 1'b0);
    add_op("rd_refill",      OP_RD, 32'h2044, WORD, 32'h0,        32'h5a5a2044, 4'd1, 1'b0, 1'b0);
    add_op("rd_refill_hit",  OP_RD, 32'h2048, WORD, 32'h0,        32'h5a5a2048, 4'd0, 1'b0, 1'b0);
  endfunction

  task automatic show_mismatch(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
    $display("mismatch %s %s expected %h actual %h", name, what, exp, act);
    errors++;
  endtask

  task automatic show_error(input string name, input string msg);
    $display("error in %s, %s", name, msg);
    errors++;
  endtask

  // called and returns just after a rising edge
  task automatic run_op(input int i);
    op_entry_t   e;
    int          s0;
    int          e0;
    logic [31:0] got_q;
    logic        got_err;
    logic        got_mis;
    e  = ops[i];
    s0 = starts;
    e0 = errors;
    case (e.op)
      OP_FW:
      begin
        if (dcflush_rdy !== 1'b0)
          show_error(names[i], "flush ready was high right after reset");
        while (dcflush_rdy !== 1'b1)
        begin
          @(negedge HCLK);
          if (HTRANS !== IDLE || mem_ack !== 1'b0)
            show_error(names[i], "bus or cpu port active during the reset flush");
        end
      end
      OP_FL:
      begin
        bu_cacheflush = 1'b1;      // one cycle pulse
        @(posedge HCLK);
        #1 bu_cacheflush = 1'b0;
        @(negedge HCLK);
        if (dcflush_rdy !== 1'b0)
          show_error(names[i], "flush ready did not drop after the flush request");
        while (dcflush_rdy !== 1'b1)
          @(negedge HCLK);
      end
      default:
      begin
        mem_adr  = e.adr;
        mem_d    = e.d;
        mem_we   = (e.op == OP_WR);
        mem_size = e.size;
        mem_req  = 1'b1;
        do
        begin
          @(negedge HCLK);
        end
        while (mem_ack !== 1'b1);
        got_q   = mem_q;
        got_err = mem_err;
        got_mis = mem_misaligned;
        if (got_mis !== e.mis)
          show_mismatch(names[i], "misaligned", 32'(e.mis), 32'(got_mis));
        if (got_err !== e.err)
          show_mismatch(names[i], "bus error", 32'(e.err), 32'(got_err));
        if (e.op == OP_RD && !e.err && !e.mis && got_q !== e.q)
          show_mismatch(names[i], "read data", e.q, got_q);
        if (e.op == OP_WR && !e.mis)
        begin
          if (last_wr_adr !== e.adr)
            show_mismatch(names[i], "write address", e.adr, last_wr_adr);
          if (last_wr_size !== e.size)
            show_mismatch(names[i], "write size", 32'(e.size), 32'(last_wr_size));
          if (last_wr_data !== e.d)
            show_mismatch(names[i], "write data", e.d, last_wr_data);
        end
      end
    endcase
    if (starts - s0 != int'(e.starts))
      show_mismatch(names[i], "bus starts", 32'(e.starts), starts - s0);
    @(posedge HCLK);
    #1 mem_req = 1'b0;               // request dropped the cycle after ack
    if (errors == e0)
      $display("test %0d %s ok", i, names[i]);
    else
    begin
      failed++;
      $display("test %0d %s failed with %0d errors", i, names[i], errors - e0);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial
  begin
    rst_n         = 1'b0;
    mem_adr       = '0;
    mem_d         = '0;
    mem_req       = 1'b0;
    mem_we        = 1'b0;
    mem_size      = WORD;
    bu_cacheflush = 1'b0;
    errors        = 0;
    failed        = 0;
    load_table();
    limit = 200 * ops.size();
    repeat (3) @(posedge HCLK);
    #1 rst_n = 1'b1;
    for (int i = 0; i < ops.size(); i++)
      run_op(i);
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             ops.size(), ops.size() - failed, failed, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: tb.f
hdl/dcache_pkg.sv
hdl/dcache_req_check.sv
hdl/dcache_beat_cnt.sv
hdl/dcache_array.sv
hdl/dcache_fsm.sv
hdl/dcache_ahb_biu.sv
hdl/dcache_ahb3lite.sv
tests/tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
# build the data cache testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_dcache -f tb.f -o tb_dcache > sim.log 2>&1 \
  && ./obj_dir/tb_dcache >> sim.log 2>&1 \
  || echo "build or simulation error" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0
